// ==== hw/axil_lb_cfg.svh ====
`ifndef AXIL_LB_CFG_SVH
`define AXIL_LB_CFG_SVH

//////////////////////////////
// axi4-lite bus geometry
//////////////////////////////

// byte address width
`define AXIL_ADDR_W 32
// data word width, strobe width follows as one bit per byte
`define AXIL_DATA_W 32

//////////////////////////////
// register bank
//////////////////////////////

// word count, word 0 is the read-only id
`define LB_NUM_REGS 8
// cycles from rd_req to rd_dval
`define LB_RD_LAT 2
// identification constant seen at word 0
`define LB_ID_VALUE 32'h4C42_0100
// returned for any offset outside the bank
`define LB_FILL_VALUE 32'hDEAD_BEEF

`endif

// ==== hw/axil_lb_pkg.sv ====
`default_nettype none

`include "axil_lb_cfg.svh"

package axil_lb_pkg;

	// byte address as seen on aw/ar channels
	typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

	// one bus data word
	typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

	// one strobe bit per data byte
	typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;

	// word index inside the register bank
	typedef logic [$clog2(`LB_NUM_REGS)-1:0] lb_reg_idx_t;

	// bresp / rresp code
	typedef logic [1:0] axil_resp_t;

endpackage

`default_nettype wire

// ==== hw/lb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lb_if
	import axil_lb_pkg::*;
();

	// write side, single-cycle strobe with address, data and byte enables
	logic       wr_stb;
	axil_addr_t wr_addr;
	axil_data_t wr_data;
	axil_strb_t wr_strb;

	// read side, one request strobe answered by one dval pulse
	logic       rd_req;
	axil_addr_t rd_addr;
	axil_data_t rd_data;
	logic       rd_dval;

	// bridge issues requests
	modport bridge (
		output wr_stb, wr_addr, wr_data, wr_strb,
		output rd_req, rd_addr,
		input  rd_data, rd_dval
	);

	// target must take every strobe, no back-pressure
	modport target (
		input  wr_stb, wr_addr, wr_data, wr_strb,
		input  rd_req, rd_addr,
		output rd_data, rd_dval
	);

endinterface

`default_nettype wire

// ==== hw/axil_lb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_lb_bridge
	import axil_lb_pkg::*;
(
	input  wire             S_AXI_ACLK,
	input  wire             S_AXI_ARESETN,

	// write address / data / response
	input  wire axil_addr_t i_awaddr,
	input  wire             i_awvalid,
	output logic            o_awready,
	input  wire axil_data_t i_wdata,
	input  wire axil_strb_t i_wstrb,
	input  wire             i_wvalid,
	output logic            o_wready,
	output axil_resp_t      o_bresp,
	output logic            o_bvalid,
	input  wire             i_bready,

	// read address / data
	input  wire axil_addr_t i_araddr,
	input  wire             i_arvalid,
	output logic            o_arready,
	output axil_data_t      o_rdata,
	output axil_resp_t      o_rresp,
	output logic            o_rvalid,
	input  wire             i_rready,

	// local bus towards the target
	lb_if.bridge            lb
);

	// no error responses are ever produced
	localparam axil_resp_t RESP_OKAY = 2'b00;

	// write side state
	logic       aw_en;
	logic       wr_start;
	logic       wr_hs;
	logic       b_hs;
	axil_addr_t awaddr_q;

	// read side state
	logic       rd_busy;
	logic       ar_start;
	logic       ar_hs;
	logic       r_hs;
	axil_addr_t araddr_q;

	//////////////////////////////
	// handshake decode
	//////////////////////////////

	// accept a write only with address and data both present
	assign wr_start = !o_awready && i_awvalid && i_wvalid && aw_en;
	// aw and w complete together in the ready cycle
	assign wr_hs    = o_awready && i_awvalid && o_wready && i_wvalid;
	assign b_hs     = o_bvalid && i_bready;

	// one read at a time, busy until the r handshake
	assign ar_start = !o_arready && i_arvalid && !rd_busy;
	assign ar_hs    = o_arready && i_arvalid;
	assign r_hs     = o_rvalid && i_rready;

	//////////////////////////////
	// write channel
	//////////////////////////////

	// awready and wready pulse together for one cycle
	// aw_en closes on accept, reopens once the response is taken
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			aw_en     <= 1'b1;
		end else begin
			o_awready <= wr_start;
			o_wready  <= wr_start;
			if (wr_start) begin
				aw_en <= 1'b0;
			end else if (b_hs) begin
				aw_en <= 1'b1;
			end
		end
	end

	// address held for the strobe cycle that follows
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_start) begin
			awaddr_q <= i_awaddr;
		end
	end

	// bvalid rises after the strobe and waits for bready
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_bvalid <= 1'b0;
		end else if (wr_hs) begin
			o_bvalid <= 1'b1;
		end else if (b_hs) begin
			o_bvalid <= 1'b0;
		end
	end

	assign o_bresp = RESP_OKAY;

	//////////////////////////////
	// read channel
	//////////////////////////////

	// arready pulses once per read, busy flag blocks the next one
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_arready <= 1'b0;
			rd_busy   <= 1'b0;
		end else begin
			o_arready <= ar_start;
			if (ar_start) begin
				rd_busy <= 1'b1;
			end else if (r_hs) begin
				rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (ar_start) begin
			araddr_q <= i_araddr;
		end
	end

	// target latency is treated as unknown, the read ends on rd_dval
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_rvalid <= 1'b0;
		end else if (lb.rd_dval) begin
			o_rvalid <= 1'b1;
		end else if (r_hs) begin
			o_rvalid <= 1'b0;
		end
	end

	// rdata captured once, stays put while rvalid waits on rready
	always_ff @(posedge S_AXI_ACLK) begin
		if (lb.rd_dval) begin
			o_rdata <= lb.rd_data;
		end
	end

	assign o_rresp = RESP_OKAY;

	//////////////////////////////
	// local bus drive
	//////////////////////////////

	// strobe in the handshake cycle, live wdata and wstrb
	assign lb.wr_stb  = wr_hs;
	assign lb.wr_addr = awaddr_q;
	assign lb.wr_data = i_wdata;
	assign lb.wr_strb = i_wstrb;

	// request also in its handshake cycle
	assign lb.rd_req  = ar_hs;
	assign lb.rd_addr = araddr_q;

endmodule

`default_nettype wire

// ==== hw/lb_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_lb_cfg.svh"

module lb_reg_bank
	import axil_lb_pkg::*;
(
	input  wire  S_AXI_ACLK,
	input  wire  S_AXI_ARESETN,
	lb_if.target lb
);

	// word index sits right above the byte offset
	localparam int IDX_LSB   = 2;
	localparam int IDX_W     = $bits(lb_reg_idx_t);
	localparam int HI_LSB    = IDX_LSB + IDX_W;
	localparam int NUM_BYTES = $bits(axil_strb_t);

	// word 0 has no storage, it is the id constant
	axil_data_t            regs [1:`LB_NUM_REGS-1];

	lb_reg_idx_t           wr_idx;
	logic                  wr_unmapped;
	logic                  wr_en;

	lb_reg_idx_t           rd_idx;
	logic                  rd_unmapped;
	axil_data_t            rd_sel;

	// read return shift pipeline
	axil_data_t            rd_pipe [`LB_RD_LAT];
	logic [`LB_RD_LAT-1:0] vld_pipe;

	//////////////////////////////
	// address decode
	//////////////////////////////

	// any address bit above the index means outside the bank
	assign wr_idx      = lb.wr_addr[HI_LSB-1:IDX_LSB];
	assign wr_unmapped = |lb.wr_addr[`AXIL_ADDR_W-1:HI_LSB];
	assign rd_idx      = lb.rd_addr[HI_LSB-1:IDX_LSB];
	assign rd_unmapped = |lb.rd_addr[`AXIL_ADDR_W-1:HI_LSB];

	// writes to the id word or unmapped space are dropped
	assign wr_en = lb.wr_stb && !wr_unmapped && (wr_idx != '0);

	//////////////////////////////
	// register storage
	//////////////////////////////

	// byte merge under wr_strb
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int i = 1; i < `LB_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			for (int b = 0; b < NUM_BYTES; b++) begin
				if (lb.wr_strb[b]) begin
					regs[wr_idx][8*b +: 8] <= lb.wr_data[8*b +: 8];
				end
			end
		end
	end

	// read source select, fill beats id beats storage
	always_comb begin
		if (rd_unmapped) begin
			rd_sel = `LB_FILL_VALUE;
		end else if (rd_idx == '0) begin
			rd_sel = `LB_ID_VALUE;
		end else begin
			rd_sel = regs[rd_idx];
		end
	end

	//////////////////////////////
	// read pipeline
	//////////////////////////////

	// stage 0 loads only on a request, later stages just shift
	// vld_pipe tracks which stages carry a real answer, so
	// several requests may be in flight back to back
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			vld_pipe <= '0;
			for (int s = 0; s < `LB_RD_LAT; s++) begin
				rd_pipe[s] <= '0;
			end
		end else begin
			vld_pipe[0] <= lb.rd_req;
			if (lb.rd_req) begin
				rd_pipe[0] <= rd_sel;
			end
			for (int s = 1; s < `LB_RD_LAT; s++) begin
				vld_pipe[s] <= vld_pipe[s-1];
				rd_pipe[s]  <= rd_pipe[s-1];
			end
		end
	end

	// last stage answers, exactly LB_RD_LAT cycles after rd_req
	assign lb.rd_data = rd_pipe[`LB_RD_LAT-1];
	assign lb.rd_dval = vld_pipe[`LB_RD_LAT-1];

endmodule

`default_nettype wire

// ==== hw/axil_lb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_lb_top
	import axil_lb_pkg::*;
(
	input  wire             S_AXI_ACLK,
	input  wire             S_AXI_ARESETN,

	// write address / data / response
	input  wire axil_addr_t i_awaddr,
	input  wire             i_awvalid,
	output wire             o_awready,
	input  wire axil_data_t i_wdata,
	input  wire axil_strb_t i_wstrb,
	input  wire             i_wvalid,
	output wire             o_wready,
	output axil_resp_t      o_bresp,
	output wire             o_bvalid,
	input  wire             i_bready,

	// read address / data
	input  wire axil_addr_t i_araddr,
	input  wire             i_arvalid,
	output wire             o_arready,
	output axil_data_t      o_rdata,
	output axil_resp_t      o_rresp,
	output wire             o_rvalid,
	input  wire             i_rready
);

	// local bus between bridge and bank
	lb_if lb_bus ();

	// axi4-lite slave side
	axil_lb_bridge bridge_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awaddr      (i_awaddr),
		.i_awvalid     (i_awvalid),
		.o_awready     (o_awready),
		.i_wdata       (i_wdata),
		.i_wstrb       (i_wstrb),
		.i_wvalid      (i_wvalid),
		.o_wready      (o_wready),
		.o_bresp       (o_bresp),
		.o_bvalid      (o_bvalid),
		.i_bready      (i_bready),
		.i_araddr      (i_araddr),
		.i_arvalid     (i_arvalid),
		.o_arready     (o_arready),
		.o_rdata       (o_rdata),
		.o_rresp       (o_rresp),
		.o_rvalid      (o_rvalid),
		.i_rready      (i_rready),
		.lb            (lb_bus.bridge)
	);

	// eight word bank with fixed read latency
	lb_reg_bank reg_bank_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.lb            (lb_bus.target)
	);

endmodule

`default_nettype wire

// ==== verif/tb_axil_lb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "axil_lb_cfg.svh"

module tb_axil_lb_top
	import axil_lb_pkg::*;
();

	localparam STIM_FILE    = "verif/axil_lb_stim.txt";
	// watchdog budget per stim line plus reset and slack
	localparam CYC_PER_LINE = 40;
	localparam CYC_MARGIN   = 100;

	logic       S_AXI_ACLK;
	logic       S_AXI_ARESETN;
	axil_addr_t awaddr, araddr;
	axil_data_t wdata, rdata;
	axil_strb_t wstrb;
	axil_resp_t bresp, rresp;
	logic       awvalid, awready, wvalid, wready, bvalid, bready;
	logic       arvalid, arready, rvalid, rready;

	// reference copy of the bank where entry 0 stays unused
	axil_data_t model [`LB_NUM_REGS];

	// stim lines with one entry per transaction
	int         num_q [$];
	logic [7:0] op_q [$];
	axil_addr_t addr_q [$];
	axil_data_t data_q [$];
	axil_strb_t strb_q [$];
	axil_data_t exp_q [$];

	int          cycles;
	int          cycle_limit;
	int          test_errs;
	int          tests_pass;
	int          tests_fail;
	logic [31:0] rng;

	axil_lb_top axil_lb_top_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awaddr      (awaddr),
		.i_awvalid     (awvalid),
		.o_awready     (awready),
		.i_wdata       (wdata),
		.i_wstrb       (wstrb),
		.i_wvalid      (wvalid),
		.o_wready      (wready),
		.o_bresp       (bresp),
		.o_bvalid      (bvalid),
		.i_bready      (bready),
		.i_araddr      (araddr),
		.i_arvalid     (arvalid),
		.o_arready     (arready),
		.o_rdata       (rdata),
		.o_rresp       (rresp),
		.o_rvalid      (rvalid),
		.i_rready      (rready)
	);

	// 8 ns clock
	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	// watchdog armed once the stim length is known
	always @(posedge S_AXI_ACLK) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout, no bus response within %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// xorshift32 step for stall lengths
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// fill above bit 4, id at word 0, else the stored word
	function automatic axil_data_t model_read(input axil_addr_t a);
		return (|a[31:5]) ? `LB_FILL_VALUE :
			(a[4:2] == 3'd0) ? `LB_ID_VALUE : model[a[4:2]];
	endfunction

	// byte merge where the id word and unmapped space ignore writes
	task automatic model_write(input axil_addr_t a, input axil_data_t d, input axil_strb_t s);
		if (!(|a[31:5]) && a[4:2] != 3'd0) begin
			for (int b = 0; b < 4; b++) begin
				if (s[b]) begin
					model[a[4:2]][8*b +: 8] = d[8*b +: 8];
				end
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic finish_test(input int num);
		if (test_errs == 0) begin
			$display("test %0d done, ok", num);
			tests_pass++;
		end else begin
			$display("test %0d done, %0d errors", num, test_errs);
			tests_fail++;
		end
		test_errs = 0;
	endtask

	//////////////////////////////
	// bus transactions
	//////////////////////////////

	// aw and w together, then b after a random bready stall
	task automatic axi_write(input axil_addr_t a, input axil_data_t d, input axil_strb_t s);
		int stall;
		rng   = next_random(rng);
		stall = rng[1:0];
		@(negedge S_AXI_ACLK);
		awaddr  = a;
		wdata   = d;
		wstrb   = s;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		while (!(awready && wready)) begin
			@(negedge S_AXI_ACLK);
		end
		// handshake lands on the rising edge in between
		@(negedge S_AXI_ACLK);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		// ready pulses last a single cycle
		if (awready || wready) begin
			$display("awready or wready stayed high after the write handshake");
			test_errs++;
		end
		while (!bvalid) begin
			@(negedge S_AXI_ACLK);
		end
		check_value("bresp", bresp, 2'b00);
		repeat (stall) begin
			@(negedge S_AXI_ACLK);
			if (!bvalid) begin
				$display("bvalid dropped before bready was given");
				test_errs++;
			end
		end
		bready = 1'b1;
		@(negedge S_AXI_ACLK);
		bready = 1'b0;
		// a second response would mean a duplicate write
		if (bvalid) begin
			$display("bvalid still high after the write response was taken");
			test_errs++;
		end
	endtask

	// ar then r after a random rready stall with latency counted from arvalid
	task automatic axi_read(input axil_addr_t a, input axil_data_t exp);
		int         stall;
		int         lat;
		axil_data_t held;
		rng   = next_random(rng);
		stall = rng[1:0];
		lat   = 0;
		@(negedge S_AXI_ACLK);
		araddr  = a;
		arvalid = 1'b1;
		while (!arready) begin
			@(negedge S_AXI_ACLK);
			lat++;
		end
		@(negedge S_AXI_ACLK);
		lat++;
		arvalid = 1'b0;
		if (arready) begin
			$display("arready stayed high after the read handshake");
			test_errs++;
		end
		while (!rvalid) begin
			@(negedge S_AXI_ACLK);
			lat++;
		end
		check_value("rvalid latency", lat, `LB_RD_LAT + 2);
		check_value("rdata", rdata, exp);
		check_value("rresp", rresp, 2'b00);
		held = rdata;
		// rdata must not move while rvalid waits
		repeat (stall) begin
			@(negedge S_AXI_ACLK);
			check_value("rdata", rdata, held);
			if (!rvalid) begin
				$display("rvalid dropped before rready was given");
				test_errs++;
			end
		end
		rready = 1'b1;
		@(negedge S_AXI_ACLK);
		rready = 1'b0;
		if (rvalid) begin
			$display("rvalid still high after the read data was taken");
			test_errs++;
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin : main_seq
		int             fd;
		int             num;
		logic [7:0]     op;
		logic [31:0]    a, d, s, e;
		logic [8*128-1:0] line;
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		cycles      = 0;
		cycle_limit = 0;
		test_errs   = 0;
		tests_pass  = 0;
		tests_fail  = 0;
		rng         = 32'd57;
		for (int i = 0; i < `LB_NUM_REGS; i++) begin
			model[i] = '0;
		end
		// lines that do not parse, comments included, are skipped
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file %s", STIM_FILE);
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ($sscanf(line, "%d %c %h %h %h %h", num, op, a, d, s, e) == 6) begin
					num_q.push_back(num);
					op_q.push_back(op);
					addr_q.push_back(a);
					data_q.push_back(d);
					strb_q.push_back(s[3:0]);
					exp_q.push_back(e);
				end
			end
			$fclose(fd);
		end
		if (num_q.size() == 0) begin
			$display("no transactions were loaded from the stimulus file");
			tests_fail++;
		end
		cycle_limit = CYC_PER_LINE * num_q.size() + CYC_MARGIN;
		repeat (3) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		for (int i = 0; i < num_q.size(); i++) begin
			// a new test number closes the previous test
			if (i > 0 && num_q[i] != num_q[i-1]) begin
				finish_test(num_q[i-1]);
			end
			if (op_q[i] == "W") begin
				axi_write(addr_q[i], data_q[i], strb_q[i]);
				model_write(addr_q[i], data_q[i], strb_q[i]);
				check_value("stim expected", model_read(addr_q[i]), exp_q[i]);
			end else if (op_q[i] == "R") begin
				check_value("stim expected", model_read(addr_q[i]), exp_q[i]);
				axi_read(addr_q[i], model_read(addr_q[i]));
			end else begin
				$display("stim line %0d has an unknown operation", i);
				test_errs++;
			end
		end
		if (num_q.size() > 0) begin
			finish_test(num_q[num_q.size()-1]);
		end
		$display("tests passed %0d, failed %0d", tests_pass, tests_fail);
		if (tests_fail == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/axil_lb_pkg.sv
hw/lb_if.sv
hw/axil_lb_bridge.sv
hw/lb_reg_bank.sv
hw/axil_lb_top.sv
verif/tb_axil_lb_top.sv

// ==== verif/axil_lb_stim.txt ====
# test op addr data strb expected, all hex except test number
# for W lines, expected is what the address reads after the write
1 R 00000000 00000000 0 4C420100
1 R 00000004 00000000 0 00000000
1 R 00000008 00000000 0 00000000
1 R 0000000C 00000000 0 00000000
1 R 00000010 00000000 0 00000000
1 R 00000014 00000000 0 00000000
1 R 00000018 00000000 0 00000000
1 R 0000001C 00000000 0 00000000
2 W 00000004 11111111 F 11111111
2 R 00000004 00000000 0 11111111
2 W 00000008 22222222 F 22222222
2 R 00000008 00000000 0 22222222
2 W 0000000C 33333333 F 33333333
2 R 0000000C 00000000 0 33333333
2 W 00000010 44444444 F 44444444
2 R 00000010 00000000 0 44444444
2 W 00000014 55555555 F 55555555
2 R 00000014 00000000 0 55555555
2 W 00000018 66666666 F 66666666
2 R 00000018 00000000 0 66666666
2 W 0000001C A5A5A5A5 F A5A5A5A5
2 R 0000001C 00000000 0 A5A5A5A5
3 W 00000004 AABBCCDD 1 111111DD
3 R 00000004 00000000 0 111111DD
3 W 00000004 AABBCCDD A AA11CCDD
3 R 00000004 00000000 0 AA11CCDD
4 W 00000000 FFFFFFFF F 4C420100
4 W 00000020 FFFFFFFF F DEADBEEF
4 R 00000000 00000000 0 4C420100
4 R 00000020 00000000 0 DEADBEEF
4 R 00001008 00000000 0 DEADBEEF
4 R 00000004 00000000 0 AA11CCDD
